//--- Makefile
.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f src.f --top-module dcache_tb -Mdir obj_dir

run: build
	./obj_dir/Vdcache_tb | tee sim.log
	grep -q "All tests passed" sim.log

lint:
	verilator --lint-only -Wall --timing -f src.f --top-module dcache

clean:
	rm -rf obj_dir sim.log

//--- dv/dcache_mem_model.sv
`timescale 1ns/10ps
`default_nettype none

module dcache_mem_model #(
    parameter int unsigned LATENCY = 2
) (
    input  logic                 CLK,
    input  logic                 nRST,
    input  dcache_pkg::mem_req_t mem_req,
    output dcache_pkg::mem_rsp_t mem_rsp,
    input  dcache_pkg::word_t    peek_addr,
    output dcache_pkg::word_t    peek_data,
    output dcache_pkg::word_t    peek_init,
    input  int unsigned          log_idx,
    output int unsigned          log_count,
    output dcache_pkg::word_t    log_addr,
    output dcache_pkg::word_t    log_data
);

    localparam int unsigned LOG_DEPTH = 256;

    dcache_pkg::word_t mem [dcache_pkg::word_t];
    dcache_pkg::word_t wr_addr [LOG_DEPTH];
    dcache_pkg::word_t wr_data [LOG_DEPTH];
    int unsigned       wr_count = 0;
    int unsigned       wait_cnt;
    logic              en;

    // unwritten words read back as a pattern of their whole address
    function automatic dcache_pkg::word_t fill_word(input dcache_pkg::word_t wa);
        return {wa[15:0], wa[31:16]} ^ 32'hc3c3_3c3c;
    endfunction

    function automatic dcache_pkg::word_t read_word(input dcache_pkg::word_t a);
        dcache_pkg::word_t wa;
        wa = {a[31:2], 2'b00};
        if (mem.exists(wa)) begin
            return mem[wa];
        end
        return fill_word(wa);
    endfunction

    assign en = mem_req.ren || mem_req.wen;

    always_comb begin
        mem_rsp.busy = en && (wait_cnt != LATENCY);
        mem_rsp.load = read_word(mem_req.addr);
        peek_data    = read_word(peek_addr);
        peek_init    = fill_word({peek_addr[31:2], 2'b00});
        log_count    = wr_count;
        log_addr     = wr_addr[log_idx[7:0]];
        log_data     = wr_data[log_idx[7:0]];
    end

    // busy for LATENCY cycles, then one cycle with busy low
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            wait_cnt <= 0;
        end else if (!en || wait_cnt == LATENCY) begin
            wait_cnt <= 0;
        end else begin
            wait_cnt <= wait_cnt + 1;
        end
    end

    always @(posedge CLK) begin
        if (nRST && mem_req.wen && !mem_rsp.busy) begin
            mem[{mem_req.addr[31:2], 2'b00}] = mem_req.store;
            if (wr_count < LOG_DEPTH) begin
                wr_addr[wr_count[7:0]] = {mem_req.addr[31:2], 2'b00};
                wr_data[wr_count[7:0]] = mem_req.store;
            end
            wr_count = wr_count + 1;
        end
    end

endmodule

`default_nettype wire

//--- dv/dcache_tb.sv
`timescale 1ns/10ps
`default_nettype none

module dcache_tb;

    localparam int unsigned ACCESS_TIMEOUT = 100;
    localparam int unsigned FLUSH_TIMEOUT  = 1000;

    logic                 CLK = 1'b0;
    logic                 nRST;
    logic                 halt;
    dcache_pkg::dp_req_t  dp_req;
    dcache_pkg::dp_rsp_t  dp_rsp;
    dcache_pkg::mem_req_t mem_req;
    dcache_pkg::mem_rsp_t mem_rsp;
    logic                 halted;
    logic                 flushed;
    dcache_pkg::word_t    peek_addr;
    dcache_pkg::word_t    peek_data;
    dcache_pkg::word_t    peek_init;
    int unsigned          log_idx;
    int unsigned          log_count;
    dcache_pkg::word_t    log_addr;
    dcache_pkg::word_t    log_data;

    // last stored value per word address
    dcache_pkg::word_t            shadow [dcache_pkg::word_t];
    logic [dcache_pkg::TAG_W-1:0] tags [4];
    integer                       seed = 32'hd611_3be6;
    int unsigned                  checks = 0;
    int unsigned                  errors = 0;
    int unsigned                  timeouts = 0;
    int unsigned                  late_enables = 0;

    dcache dut_i (.*);

    dcache_mem_model #(.LATENCY(2)) mem_i (.*);

    always #4 CLK = ~CLK;

    always @(negedge CLK) begin
        if (flushed && (mem_req.ren || mem_req.wen)) begin
            late_enables++;
        end
    end

    function automatic dcache_pkg::word_t make_addr(input int t, input logic [2:0] idx,
                                                    input logic off);
        return {tags[t], idx, off, 2'b00};
    endfunction

    task automatic check_value(input string name, input dcache_pkg::word_t got,
                               input dcache_pkg::word_t exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("[ERROR] %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic require(input logic cond, input string what);
        checks++;
        assert (cond) else begin
            errors++;
            $display("check failed: %s", what);
        end
    endtask

    // holds one request until hit
    // entered and left a short delay after the edge
    task automatic access(input logic wr, input dcache_pkg::word_t addr,
                          input dcache_pkg::word_t data, output dcache_pkg::word_t load,
                          output int unsigned cycles, output logic mem_used);
        logic done;
        done         = 1'b0;
        cycles       = 0;
        mem_used     = 1'b0;
        load         = '0;
        dp_req.ren   = !wr;
        dp_req.wen   = wr;
        dp_req.addr  = addr;
        dp_req.store = data;
        while (!done && cycles < ACCESS_TIMEOUT) begin
            @(negedge CLK);
            mem_used = mem_used || mem_req.ren || mem_req.wen;
            if (dp_rsp.hit) begin
                done = 1'b1;
                load = dp_rsp.load;
            end else begin
                cycles++;
            end
        end
        if (!done) begin
            timeouts++;
            $display("timeout: no hit for the request at address %h", addr);
        end
        @(posedge CLK);
        #1;
        dp_req = '0;
    endtask

    task automatic load_and_check(input dcache_pkg::word_t addr, output int unsigned cycles,
                                  output logic mem_used);
        dcache_pkg::word_t got;
        peek_addr = addr;
        access(1'b0, addr, '0, got, cycles, mem_used);
        check_value($sformatf("dp_rsp.load @%h", addr), got,
                    shadow.exists(addr) ? shadow[addr] : peek_init);
    endtask

    task automatic store_word(input dcache_pkg::word_t addr, input dcache_pkg::word_t data);
        dcache_pkg::word_t got;
        int unsigned       cycles;
        logic              mem_used;
        access(1'b1, addr, data, got, cycles, mem_used);
        shadow[addr] = data;
    endtask

    task automatic read_log(input int unsigned idx, output dcache_pkg::word_t addr,
                            output dcache_pkg::word_t data);
        log_idx = idx;
        @(negedge CLK);
        addr = log_addr;
        data = log_data;
        @(posedge CLK);
        #1;
    endtask

    initial begin
        logic [31:0]       r;
        dcache_pkg::word_t a;
        dcache_pkg::word_t wa;
        dcache_pkg::word_t wd;
        int unsigned       cycles;
        int unsigned       waited;
        int unsigned       log_base;
        logic              mem_used;
        logic              held;
        logic [2:0]        set;

        nRST      = 1'b0;
        halt      = 1'b0;
        dp_req    = '0;
        peek_addr = '0;
        log_idx   = 0;
        // low two bits keep the tags distinct
        for (int i = 0; i < 4; i++) begin
            r       = $random(seed);
            tags[i] = {r[25:2], 2'(i)};
        end
        repeat (5) @(posedge CLK);
        #1;
        nRST = 1'b1;
        @(negedge CLK);
        require(!dp_rsp.hit && !mem_req.ren && !mem_req.wen && !halted && !flushed,
                "outputs not idle after reset");
        @(posedge CLK);
        #1;

        r   = $random(seed);
        set = r[2:0];
        a   = make_addr(0, set, 1'b0);
        load_and_check(a, cycles, mem_used);
        require(cycles > 0 && mem_used, "read of a fresh address did not use memory");
        load_and_check(a, cycles, mem_used);
        require(cycles == 0 && !mem_used, "repeated read did not hit in its first cycle");

        store_word(make_addr(0, set, 1'b1), $random(seed));
        load_and_check(make_addr(0, set, 1'b1), cycles, mem_used);
        load_and_check(a, cycles, mem_used);

        // tag 2 evicts the dirty tag 0 block
        store_word(a, $random(seed));
        load_and_check(make_addr(1, set, 1'b0), cycles, mem_used);
        log_base = log_count;
        load_and_check(make_addr(2, set, 1'b1), cycles, mem_used);
        require(log_count == log_base + 2, "dirty eviction did not write back two words");
        for (int w = 0; w < 2; w++) begin
            read_log(log_base + w, wa, wd);
            check_value("write-back addr", wa, make_addr(0, set, 1'(w)));
            check_value("write-back data", wd, shadow[make_addr(0, set, 1'(w))]);
        end

        // half of the traffic collides in one set
        for (int n = 0; n < 60; n++) begin
            r = $random(seed);
            a = make_addr(int'(r[1:0]), r[2] ? set : r[5:3], r[6]);
            if (r[7]) begin
                store_word(a, $random(seed));
            end else begin
                load_and_check(a, cycles, mem_used);
            end
        end

        // leave a dirty block for the flush walk
        store_word(make_addr(3, set, 1'b1), $random(seed));

        halt   = 1'b1;
        waited = 0;
        while (!halted && waited < ACCESS_TIMEOUT) begin
            @(negedge CLK);
            waited++;
        end
        if (!halted) begin
            timeouts++;
            $display("timeout: halted did not rise after halt");
        end
        held   = 1'b1;
        waited = 0;
        while (!flushed && waited < FLUSH_TIMEOUT) begin
            @(negedge CLK);
            waited++;
            held = held && halted;
        end
        if (!flushed) begin
            timeouts++;
            $display("timeout: flushed did not rise after halt");
        end
        repeat (20) begin
            @(negedge CLK);
            held = held && halted && flushed;
        end
        require(held, "halted or flushed dropped during the halt");
        foreach (shadow[k]) begin
            peek_addr = k;
            @(negedge CLK);
            check_value($sformatf("memory @%h", k), peek_data, shadow[k]);
        end
        require(late_enables == 0, "memory enable seen after flushed");

        $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- hdl/dcache.sv
`timescale 1ns/10ps
`default_nettype none

module dcache (
    input  logic                  CLK,
    input  logic                  nRST,
    input  dcache_pkg::dp_req_t   dp_req,
    input  logic                  halt,
    output dcache_pkg::dp_rsp_t   dp_rsp,
    output dcache_pkg::mem_req_t  mem_req,
    input  dcache_pkg::mem_rsp_t  mem_rsp,
    output logic                  halted,
    output logic                  flushed
);

    logic                          hit;
    dcache_pkg::word_t             hit_word;
    dcache_pkg::dcache_block_t     victim;
    dcache_pkg::dcache_block_t     peek_block;
    dcache_pkg::dcache_block_t     fill_block;
    logic                          touch;
    logic                          store_en;
    logic                          fill_en;
    logic                          peek_way;
    logic [dcache_pkg::IDX_W-1:0]  peek_idx;
    dcache_pkg::mem_req_t          ctrl_mem_req;
    dcache_pkg::mem_req_t          flush_mem_req;

    dcache_ways u_ways (
        .CLK        (CLK),
        .nRST       (nRST),
        .look_addr  (dp_req.addr),
        .touch      (touch),
        .store_en   (store_en),
        .store_data (dp_req.store),
        .fill_en    (fill_en),
        .fill_block (fill_block),
        .peek_way   (peek_way),
        .peek_idx   (peek_idx),
        .hit        (hit),
        .hit_word   (hit_word),
        .victim     (victim),
        .peek_block (peek_block)
    );

    dcache_ctrl u_ctrl (
        .CLK        (CLK),
        .nRST       (nRST),
        .req        (dp_req),
        .halt       (halt),
        .hit        (hit),
        .hit_word   (hit_word),
        .victim     (victim),
        .mem_rsp    (mem_rsp),
        .rsp        (dp_rsp),
        .touch      (touch),
        .store_en   (store_en),
        .fill_en    (fill_en),
        .fill_block (fill_block),
        .mem_req    (ctrl_mem_req),
        .halted     (halted)
    );

    dcache_flush u_flush (
        .CLK        (CLK),
        .nRST       (nRST),
        .halted     (halted),
        .peek_block (peek_block),
        .mem_rsp    (mem_rsp),
        .peek_way   (peek_way),
        .peek_idx   (peek_idx),
        .mem_req    (flush_mem_req),
        .flushed    (flushed)
    );

    // walker owns the memory port once halted
    assign mem_req = halted ? flush_mem_req : ctrl_mem_req;

endmodule

`default_nettype wire

//--- hdl/dcache_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module dcache_ctrl (
    input  logic                      CLK,
    input  logic                      nRST,
    input  dcache_pkg::dp_req_t       req,
    input  logic                      halt,
    input  logic                      hit,
    input  dcache_pkg::word_t         hit_word,
    input  dcache_pkg::dcache_block_t victim,
    input  dcache_pkg::mem_rsp_t      mem_rsp,
    output dcache_pkg::dp_rsp_t       rsp,
    output logic                      touch,
    output logic                      store_en,
    output logic                      fill_en,
    output dcache_pkg::dcache_block_t fill_block,
    output dcache_pkg::mem_req_t      mem_req,
    output logic                      halted
);

    typedef enum logic [2:0] {
        IDLE,
        STORE,
        WB_FIRST,
        WB_SECOND,
        FETCH_FIRST,
        FETCH_SECOND,
        HALT
    } state_t;

    state_t state;
    state_t state_next;

    // first word of the block being fetched
    dcache_pkg::word_t fetch_word0;

    logic access;
    logic victim_dirty;

    assign access       = req.ren || req.wen;
    assign victim_dirty = victim.valid && victim.dirty;
    assign halted       = (state == HALT);

    // new block goes in clean, second word straight from memory
    always_comb begin
        fill_block.word0 = fetch_word0;
        fill_block.word1 = mem_rsp.load;
        fill_block.tag   = req.addr.tag;
        fill_block.dirty = 1'b0;
        fill_block.valid = 1'b1;
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_ff @(posedge CLK) begin
        if (state == FETCH_FIRST && !mem_rsp.busy) begin
            fetch_word0 <= mem_rsp.load;
        end
    end

    always_comb begin
        state_next = state;
        rsp        = '0;
        touch      = 1'b0;
        store_en   = 1'b0;
        fill_en    = 1'b0;
        mem_req    = '0;

        case (state)
            IDLE: begin
                if (halt) begin
                    state_next = HALT;
                end else if (access && hit) begin
                    if (req.wen) begin
                        state_next = STORE;
                    end else begin
                        rsp.hit  = 1'b1;
                        rsp.load = hit_word;
                        touch    = 1'b1;
                    end
                end else if (access) begin
                    state_next = victim_dirty ? WB_FIRST : FETCH_FIRST;
                end
            end
            STORE: begin
                store_en   = 1'b1;
                rsp.hit    = 1'b1;
                state_next = IDLE;
            end
            WB_FIRST: begin
                mem_req.wen   = 1'b1;
                mem_req.addr  = {victim.tag, req.addr.idx, 1'b0, 2'b00};
                mem_req.store = victim.word0;
                if (!mem_rsp.busy) begin
                    state_next = WB_SECOND;
                end
            end
            WB_SECOND: begin
                mem_req.wen   = 1'b1;
                mem_req.addr  = {victim.tag, req.addr.idx, 1'b1, 2'b00};
                mem_req.store = victim.word1;
                if (!mem_rsp.busy) begin
                    state_next = FETCH_FIRST;
                end
            end
            FETCH_FIRST: begin
                mem_req.ren  = 1'b1;
                mem_req.addr = {req.addr.tag, req.addr.idx, 1'b0, 2'b00};
                if (!mem_rsp.busy) begin
                    state_next = FETCH_SECOND;
                end
            end
            FETCH_SECOND: begin
                mem_req.ren  = 1'b1;
                mem_req.addr = {req.addr.tag, req.addr.idx, 1'b1, 2'b00};
                // victim way is replaced, request hits back in idle
                if (!mem_rsp.busy) begin
                    fill_en    = 1'b1;
                    state_next = IDLE;
                end
            end
            HALT: begin
                state_next = HALT;
            end
            default: begin
                state_next = IDLE;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- hdl/dcache_flush.sv
`timescale 1ns/10ps
`default_nettype none

module dcache_flush (
    input  logic                          CLK,
    input  logic                          nRST,
    input  logic                          halted,
    input  dcache_pkg::dcache_block_t     peek_block,
    input  dcache_pkg::mem_rsp_t          mem_rsp,
    output logic                          peek_way,
    output logic [dcache_pkg::IDX_W-1:0]  peek_idx,
    output dcache_pkg::mem_req_t          mem_req,
    output logic                          flushed
);

    localparam int unsigned CNT_W = $clog2(dcache_pkg::FLUSH_WORDS) + 1;

    // cnt = {way, word, set}
    logic [CNT_W-1:0] cnt;
    logic             done;
    logic             word_sel;
    logic             dirty_word;
    logic             advance;

    assign done     = (cnt == CNT_W'(dcache_pkg::FLUSH_WORDS));
    assign peek_idx = cnt[dcache_pkg::IDX_W-1:0];
    assign word_sel = cnt[dcache_pkg::IDX_W];
    assign peek_way = cnt[dcache_pkg::IDX_W+1];

    assign dirty_word = halted && !done && peek_block.valid && peek_block.dirty;

    // clean words skip in one cycle, dirty ones wait on memory
    assign advance = halted && !done && (!dirty_word || !mem_rsp.busy);

    always_comb begin
        mem_req       = '0;
        mem_req.wen   = dirty_word;
        mem_req.addr  = {peek_block.tag, peek_idx, word_sel, 2'b00};
        mem_req.store = word_sel ? peek_block.word1 : peek_block.word0;
    end

    assign flushed = done;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            cnt <= '0;
        end else if (advance) begin
            cnt <= cnt + 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- hdl/dcache_pkg.sv
`default_nettype none

package dcache_pkg;

    typedef logic [31:0] word_t;

    // cache geometry
    localparam int unsigned NUM_SETS    = 8;
    localparam int unsigned IDX_W       = 3;
    localparam int unsigned TAG_W       = 26;
    localparam int unsigned FLUSH_WORDS = 32;

    // processor byte address
    typedef struct packed {
        logic [TAG_W-1:0] tag;
        logic [IDX_W-1:0] idx;
        logic             blkoff;
        logic [1:0]       bytoff;
    } dcache_addr_t;

    typedef struct packed {
        word_t            word0;
        word_t            word1;
        logic [TAG_W-1:0] tag;
        logic             dirty;
        logic             valid;
    } dcache_block_t;

    typedef struct packed {
        logic         ren;
        logic         wen;
        dcache_addr_t addr;
        word_t        store;
    } dp_req_t;

    typedef struct packed {
        logic  hit;
        word_t load;
    } dp_rsp_t;

    typedef struct packed {
        logic  ren;
        logic  wen;
        word_t addr;
        word_t store;
    } mem_req_t;

    // busy is the memory wait level
    typedef struct packed {
        logic  busy;
        word_t load;
    } mem_rsp_t;

endpackage

`default_nettype wire

//--- hdl/dcache_ways.sv
`timescale 1ns/10ps
`default_nettype none

module dcache_ways (
    input  logic                             CLK,
    input  logic                             nRST,
    input  dcache_pkg::dcache_addr_t         look_addr,
    input  logic                             touch,
    input  logic                             store_en,
    input  dcache_pkg::word_t                store_data,
    input  logic                             fill_en,
    input  dcache_pkg::dcache_block_t        fill_block,
    input  logic                             peek_way,
    input  logic [dcache_pkg::IDX_W-1:0]     peek_idx,
    output logic                             hit,
    output dcache_pkg::word_t                hit_word,
    output dcache_pkg::dcache_block_t        victim,
    output dcache_pkg::dcache_block_t        peek_block
);

    // block payload indexed [way][set]
    dcache_pkg::word_t             word0_q [2][dcache_pkg::NUM_SETS];
    dcache_pkg::word_t             word1_q [2][dcache_pkg::NUM_SETS];
    logic [dcache_pkg::TAG_W-1:0]  tag_q   [2][dcache_pkg::NUM_SETS];

    logic [1:0][dcache_pkg::NUM_SETS-1:0] valid_q;
    logic [1:0][dcache_pkg::NUM_SETS-1:0] dirty_q;
    // way to replace next in each set
    logic [dcache_pkg::NUM_SETS-1:0]      lru_q;

    logic [dcache_pkg::IDX_W-1:0] idx;
    logic [1:0]                   match;
    logic                         hit_way;
    logic                         vic_way;

    assign idx = look_addr.idx;

    assign match[0] = valid_q[0][idx] && (tag_q[0][idx] == look_addr.tag);
    assign match[1] = valid_q[1][idx] && (tag_q[1][idx] == look_addr.tag);

    assign hit     = |match;
    assign hit_way = match[1];
    assign vic_way = lru_q[idx];

    assign hit_word = look_addr.blkoff ? word1_q[hit_way][idx] : word0_q[hit_way][idx];

    always_comb begin
        victim.word0 = word0_q[vic_way][idx];
        victim.word1 = word1_q[vic_way][idx];
        victim.tag   = tag_q[vic_way][idx];
        victim.dirty = dirty_q[vic_way][idx];
        victim.valid = valid_q[vic_way][idx];
    end

    // flush walker view
    always_comb begin
        peek_block.word0 = word0_q[peek_way][peek_idx];
        peek_block.word1 = word1_q[peek_way][peek_idx];
        peek_block.tag   = tag_q[peek_way][peek_idx];
        peek_block.dirty = dirty_q[peek_way][peek_idx];
        peek_block.valid = valid_q[peek_way][peek_idx];
    end

    always_ff @(posedge CLK) begin
        if (fill_en) begin
            word0_q[vic_way][idx] <= fill_block.word0;
            word1_q[vic_way][idx] <= fill_block.word1;
            tag_q[vic_way][idx]   <= fill_block.tag;
        end else if (store_en && hit) begin
            if (look_addr.blkoff) begin
                word1_q[hit_way][idx] <= store_data;
            end else begin
                word0_q[hit_way][idx] <= store_data;
            end
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            valid_q <= '0;
            dirty_q <= '0;
            lru_q   <= '0;
        end else if (fill_en) begin
            valid_q[vic_way][idx] <= fill_block.valid;
            dirty_q[vic_way][idx] <= fill_block.dirty;
            lru_q[idx]            <= ~vic_way;
        end else if (store_en && hit) begin
            dirty_q[hit_way][idx] <= 1'b1;
            lru_q[idx]            <= ~hit_way;
        end else if (touch && hit) begin
            lru_q[idx] <= ~hit_way;
        end
    end

endmodule

`default_nettype wire

//--- src.f
hdl/dcache_pkg.sv
hdl/dcache_ways.sv
hdl/dcache_ctrl.sv
hdl/dcache_flush.sv
hdl/dcache.sv
dv/dcache_mem_model.sv
dv/dcache_tb.sv
